/* Makefile */
TOOL       = verilator
TOP        = tb_exec_unit
FILELIST   = filelist.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
PASS_MSG   = === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* common/exec_pkg.sv */
// shared widths, types, opcodes, condition codes and APB register map for the execution lane
`default_nettype none

package exec_pkg;

  localparam int NUM_REGS = 16;
  localparam int APB_AW = 8;
  localparam int WORD_W = 64;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [3:0] reg_idx_t;

  // c is the msb, z the lsb
  typedef struct packed {
    logic c;
    logic v;
    logic n;
    logic z;
  } flags_t;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_XOR  = 4'd3,
    OP_OR   = 4'd4,
    OP_SHL  = 4'd5,
    OP_SHR  = 4'd6,
    OP_SAR  = 4'd7,
    OP_SXT  = 4'd8,
    OP_MOVI = 4'd9,
    OP_ADDI = 4'd10
  } opcode_e;

  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } cond_e;

  // command word fields, each four bits wide
  localparam int CMD_FIELD_W = 4;
  localparam int CMD_OP_LSB = 0;
  localparam int CMD_COND_LSB = 4;
  localparam int CMD_RD_LSB = 8;
  localparam int CMD_RA_LSB = 12;
  localparam int CMD_RB_LSB = 16;

  // byte offsets of the host registers
  typedef enum logic [APB_AW-1:0] {
    ADDR_CMD     = 8'h00,
    ADDR_IMM_LO  = 8'h04,
    ADDR_IMM_HI  = 8'h08,
    ADDR_REG_SEL = 8'h0C,
    ADDR_DATA_LO = 8'h10,
    ADDR_DATA_HI = 8'h14,
    ADDR_FLAGS   = 8'h18
  } apb_addr_e;

endpackage

`default_nettype wire

/* filelist.f */
common/exec_pkg.sv
hw/reg_file.sv
int_alu/int_alu.sv
hw/exec_ctrl.sv
hw/exec_unit_top.sv
sim/exec_unit_properties.sv
sim/tb_exec_unit.sv

/* hw/exec_ctrl.sv */
// APB slave for the execution lane: register map, three-step command sequence, file steering
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl #(
  parameter int NUM_REGS = exec_pkg::NUM_REGS
) (
  input wire clk,
  input wire rst,
  input wire psel,
  input wire penable,
  input wire pwrite,
  input wire [exec_pkg::APB_AW-1:0] paddr,
  input wire [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  output logic data_we,
  output exec_pkg::reg_idx_t data_waddr,
  output exec_pkg::word_t data_wdata,
  output exec_pkg::reg_idx_t [1:0] data_raddr,
  input wire exec_pkg::word_t [1:0] data_rdata,
  output logic flag_we,
  output exec_pkg::reg_idx_t flag_waddr,
  output exec_pkg::flags_t flag_wdata,
  output exec_pkg::reg_idx_t flag_raddr,
  input wire exec_pkg::flags_t flag_rdata,
  output exec_pkg::opcode_e alu_op,
  output exec_pkg::cond_e alu_cond,
  output exec_pkg::word_t alu_imm,
  input wire exec_pkg::word_t alu_result,
  input wire exec_pkg::flags_t alu_flags,
  input wire alu_commit
);

  localparam logic [1:0] STEP_READ = 2'd0;
  localparam logic [1:0] STEP_EXEC = 2'd1;
  localparam logic [1:0] STEP_WB = 2'd2;

  logic access;
  logic cmd_wr;
  logic mapped;
  logic sel_bad;
  logic wr_done;
  logic wb;
  logic [1:0] step;
  logic [31:0] rd_mux;
  exec_pkg::reg_idx_t cmd_rd;
  exec_pkg::reg_idx_t cmd_ra;
  exec_pkg::reg_idx_t cmd_rb;
  exec_pkg::reg_idx_t reg_sel;
  exec_pkg::word_t imm_q;
  logic [31:0] data_lo_q;
  exec_pkg::word_t res_q;
  exec_pkg::flags_t flags_q;
  logic commit_q;

  assign access = psel && penable;
  assign cmd_wr = access && pwrite && (paddr == exec_pkg::ADDR_CMD);

  // pwdata stays stable for the whole command
  assign cmd_rd = pwdata[exec_pkg::CMD_RD_LSB +: exec_pkg::CMD_FIELD_W];
  assign cmd_ra = pwdata[exec_pkg::CMD_RA_LSB +: exec_pkg::CMD_FIELD_W];
  assign cmd_rb = pwdata[exec_pkg::CMD_RB_LSB +: exec_pkg::CMD_FIELD_W];
  assign alu_op = exec_pkg::opcode_e'(pwdata[exec_pkg::CMD_OP_LSB +: exec_pkg::CMD_FIELD_W]);
  assign alu_cond = exec_pkg::cond_e'(pwdata[exec_pkg::CMD_COND_LSB +: exec_pkg::CMD_FIELD_W]);
  assign alu_imm = imm_q;

  always_comb begin
    mapped = 1'b1;
    rd_mux = '0;
    case (paddr)
      exec_pkg::ADDR_CMD: rd_mux = '0;
      exec_pkg::ADDR_IMM_LO: rd_mux = imm_q[31:0];
      exec_pkg::ADDR_IMM_HI: rd_mux = imm_q[63:32];
      exec_pkg::ADDR_REG_SEL: rd_mux = 32'(reg_sel);
      exec_pkg::ADDR_DATA_LO: rd_mux = data_rdata[0][31:0];
      exec_pkg::ADDR_DATA_HI: rd_mux = data_rdata[0][63:32];
      exec_pkg::ADDR_FLAGS: rd_mux = 32'(flag_rdata);
      default: mapped = 1'b0;
    endcase
  end

  // selector beyond the file size is rejected
  assign sel_bad = pwrite && (paddr == exec_pkg::ADDR_REG_SEL) &&
                   (pwdata >= 32'(NUM_REGS));

  assign pready = access && (!cmd_wr || step == STEP_WB);
  assign pslverr = pready && (!mapped || sel_bad);
  assign prdata = (pready && !pwrite) ? rd_mux : '0;
  assign wr_done = pready && pwrite && !pslverr;

  // port 0 follows the selected register between commands
  assign data_raddr[0] = cmd_wr ? cmd_ra : reg_sel;
  assign data_raddr[1] = cmd_wr ? cmd_rb : reg_sel;
  assign flag_raddr = cmd_wr ? cmd_ra : reg_sel;

  assign wb = cmd_wr && (step == STEP_WB) && commit_q;
  assign data_we = wb || (wr_done && paddr == exec_pkg::ADDR_DATA_HI);
  assign data_waddr = cmd_wr ? cmd_rd : reg_sel;
  assign data_wdata = cmd_wr ? res_q : {pwdata, data_lo_q};
  assign flag_we = wb;
  assign flag_waddr = cmd_rd;
  assign flag_wdata = flags_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      step <= STEP_READ;
      commit_q <= 1'b0;
      reg_sel <= '0;
      imm_q <= '0;
    end else begin
      if (!cmd_wr || step == STEP_WB) begin
        step <= STEP_READ;
      end else begin
        step <= step + 2'd1;
      end
      if (cmd_wr && step == STEP_EXEC) begin
        commit_q <= alu_commit;
      end
      if (wr_done) begin
        case (paddr)
          exec_pkg::ADDR_IMM_LO: imm_q[31:0] <= pwdata;
          exec_pkg::ADDR_IMM_HI: imm_q[63:32] <= pwdata;
          exec_pkg::ADDR_REG_SEL: reg_sel <= exec_pkg::reg_idx_t'(pwdata);
          default: ;
        endcase
      end
    end
  end

  // alu output captured in the second command cycle
  always_ff @(posedge clk) begin
    if (cmd_wr && step == STEP_EXEC) begin
      res_q <= alu_result;
      flags_q <= alu_flags;
    end
    if (wr_done && paddr == exec_pkg::ADDR_DATA_LO) begin
      data_lo_q <= pwdata;
    end
  end

endmodule

`default_nettype wire

/* hw/exec_unit_top.sv */
// top level of the execution lane: APB controller, data and flag register files, ALU
`timescale 1ns/1ps
`default_nettype none

module exec_unit_top #(
  parameter int NUM_REGS = exec_pkg::NUM_REGS
) (
  input wire clk,
  input wire rst,
  input wire psel,
  input wire penable,
  input wire pwrite,
  input wire [exec_pkg::APB_AW-1:0] paddr,
  input wire [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr
);

  logic data_we;
  exec_pkg::reg_idx_t data_waddr;
  exec_pkg::word_t data_wdata;
  exec_pkg::reg_idx_t [1:0] data_raddr;
  exec_pkg::word_t [1:0] data_rdata;
  logic flag_we;
  exec_pkg::reg_idx_t flag_waddr;
  exec_pkg::flags_t flag_wdata;
  exec_pkg::reg_idx_t flag_raddr;
  exec_pkg::flags_t flag_rdata;
  exec_pkg::opcode_e alu_op;
  exec_pkg::cond_e alu_cond;
  exec_pkg::word_t alu_imm;
  exec_pkg::word_t alu_result;
  exec_pkg::flags_t alu_flags;
  logic alu_commit;

  exec_ctrl #(.NUM_REGS(NUM_REGS)) ctrl (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .data_we, .data_waddr, .data_wdata, .data_raddr, .data_rdata,
    .flag_we, .flag_waddr, .flag_wdata, .flag_raddr, .flag_rdata,
    .alu_op, .alu_cond, .alu_imm, .alu_result, .alu_flags, .alu_commit
  );

  reg_file #(
    .entry_t(exec_pkg::word_t), .NUM_REGS(NUM_REGS), .NUM_READ(2)
  ) data_rf (
    .clk, .rst, .we(data_we), .waddr(data_waddr), .wdata(data_wdata),
    .raddr(data_raddr), .rdata(data_rdata)
  );

  reg_file #(
    .entry_t(exec_pkg::flags_t), .NUM_REGS(NUM_REGS), .NUM_READ(1)
  ) flag_rf (
    .clk, .rst, .we(flag_we), .waddr(flag_waddr), .wdata(flag_wdata),
    .raddr(flag_raddr), .rdata(flag_rdata)
  );

  int_alu alu (
    .op(alu_op), .cond(alu_cond), .a(data_rdata[0]), .b(data_rdata[1]), .imm(alu_imm),
    .flags_in(flag_rdata), .result(alu_result), .flags_out(alu_flags), .commit(alu_commit)
  );

endmodule

`default_nettype wire

/* hw/reg_file.sv */
// register array with one write port and registered read ports, shared by data and flag files
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter type entry_t = exec_pkg::word_t,
  parameter int NUM_REGS = exec_pkg::NUM_REGS,
  parameter int NUM_READ = 1
) (
  input wire clk,
  input wire rst,
  input wire we,
  input wire exec_pkg::reg_idx_t waddr,
  input wire entry_t wdata,
  input wire exec_pkg::reg_idx_t [NUM_READ-1:0] raddr,
  output entry_t [NUM_READ-1:0] rdata
);

  entry_t mem [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // one cycle of read latency on every port
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else begin
      for (int p = 0; p < NUM_READ; p++) begin
        rdata[p] <= mem[raddr[p]];
      end
    end
  end

endmodule

`default_nettype wire

/* int_alu/int_alu.sv */
// combinational integer ALU: condition test, add/sub, logic, shifts, extension and flags
`timescale 1ns/1ps
`default_nettype none

module int_alu (
  input wire exec_pkg::opcode_e op,
  input wire exec_pkg::cond_e cond,
  input wire exec_pkg::word_t a,
  input wire exec_pkg::word_t b,
  input wire exec_pkg::word_t imm,
  input wire exec_pkg::flags_t flags_in,
  output exec_pkg::word_t result,
  output exec_pkg::flags_t flags_out,
  output logic commit
);

  logic cond_ok;
  logic op_valid;
  logic is_add;
  logic is_sub;
  logic signs_ne;
  exec_pkg::word_t addend;
  logic [64:0] sum;
  logic [5:0] shamt;

  // condition test on the flags of ra
  assign signs_ne = flags_in.n ^ flags_in.v;

  always_comb begin
    case (cond)
      exec_pkg::COND_EQ: cond_ok = flags_in.z;
      exec_pkg::COND_NE: cond_ok = !flags_in.z;
      exec_pkg::COND_CS: cond_ok = flags_in.c;
      exec_pkg::COND_CC: cond_ok = !flags_in.c;
      exec_pkg::COND_MI: cond_ok = flags_in.n;
      exec_pkg::COND_PL: cond_ok = !flags_in.n;
      exec_pkg::COND_VS: cond_ok = flags_in.v;
      exec_pkg::COND_VC: cond_ok = !flags_in.v;
      exec_pkg::COND_HI: cond_ok = flags_in.c && !flags_in.z;
      exec_pkg::COND_LS: cond_ok = !flags_in.c || flags_in.z;
      exec_pkg::COND_GE: cond_ok = !signs_ne;
      exec_pkg::COND_LT: cond_ok = signs_ne;
      exec_pkg::COND_GT: cond_ok = !signs_ne && !flags_in.z;
      exec_pkg::COND_LE: cond_ok = signs_ne || flags_in.z;
      exec_pkg::COND_AL: cond_ok = 1'b1;
      default: cond_ok = 1'b0;
    endcase
  end

  assign is_sub = (op == exec_pkg::OP_SUB);
  assign is_add = (op == exec_pkg::OP_ADD) || is_sub || (op == exec_pkg::OP_ADDI);

  // sub is a + ~b + 1, so carry out means no borrow
  always_comb begin
    case (op)
      exec_pkg::OP_SUB: addend = ~b;
      exec_pkg::OP_ADDI: addend = imm;
      default: addend = b;
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, addend} + {64'd0, is_sub};

  // only the low six bits count
  assign shamt = b[5:0];

  always_comb begin
    op_valid = 1'b1;
    case (op)
      exec_pkg::OP_ADD,
      exec_pkg::OP_SUB,
      exec_pkg::OP_ADDI: result = sum[63:0];
      exec_pkg::OP_AND: result = a & b;
      exec_pkg::OP_XOR: result = a ^ b;
      exec_pkg::OP_OR: result = a | b;
      exec_pkg::OP_SHL: result = a << shamt;
      exec_pkg::OP_SHR: result = a >> shamt;
      exec_pkg::OP_SAR: result = $signed(a) >>> shamt;
      exec_pkg::OP_SXT: result = {{32{a[31]}}, a[31:0]};
      exec_pkg::OP_MOVI: result = imm;
      default: begin
        // unassigned opcodes never write back
        result = '0;
        op_valid = 1'b0;
      end
    endcase
  end

  always_comb begin
    flags_out = '0;
    if (is_add) begin
      flags_out.c = sum[64];
      flags_out.v = (a[63] == addend[63]) && (sum[63] != a[63]);
    end
    flags_out.n = result[63];
    flags_out.z = (result == '0);
  end

  assign commit = cond_ok && op_valid;

endmodule

`default_nettype wire

/* sim/exec_unit_properties.sv */
// APB protocol assertions on the lane's host port, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module exec_unit_properties (
  input wire clk,
  input wire rst,
  input wire psel,
  input wire penable,
  input wire pwrite,
  input wire [exec_pkg::APB_AW-1:0] paddr,
  input wire pready,
  input wire pslverr
);

  logic cmd;

  assign cmd = pwrite && (paddr == exec_pkg::ADDR_CMD);

  ready_in_access: assert property (@(posedge clk) disable iff (rst)
    pready |-> psel && penable) else $error("pready outside an access cycle");

  err_with_ready: assert property (@(posedge clk) disable iff (rst)
    pslverr |-> pready) else $error("pslverr without pready");

  // register accesses have no wait states
  plain_one_cycle: assert property (@(posedge clk) disable iff (rst)
    psel && penable && !cmd |-> pready) else $error("register access took wait states");

  // two wait states, pready in the third access cycle
  cmd_three_cycles: assert property (@(posedge clk) disable iff (rst)
    psel && !penable && cmd |=> !pready ##1 !pready ##1 pready)
    else $error("command write did not complete in its third access cycle");

endmodule

bind exec_unit_top exec_unit_properties props (
  .clk, .rst, .psel, .penable, .pwrite, .paddr, .pready, .pslverr
);

`default_nettype wire

/* sim/tb_exec_unit.sv */
// directed testbench for the execution lane: APB access, ALU reference model, register checks
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit;

  localparam int NUM_TESTS = 6;
  localparam int MAX_WAIT = 8;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic psel = 1'b0;
  logic penable = 1'b0;
  logic pwrite = 1'b0;
  logic [exec_pkg::APB_AW-1:0] paddr = '0;
  logic [31:0] pwdata = '0;
  wire [31:0] prdata;
  wire pready;
  wire pslverr;

  integer seed = 32'h6b6f;
  int errors = 0;
  int checks = 0;
  int cycles;
  logic [31:0] rdata;
  bit err;
  // expected contents of both register files
  exec_pkg::word_t regs [16] = '{default: '0};
  exec_pkg::flags_t flags [16] = '{default: '0};
  exec_pkg::word_t imm = '0;

  exec_unit_top #(.NUM_REGS(16)) uut (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  always #20 clk = ~clk;

  initial begin
    #(20_000 * NUM_TESTS);
    $display("watchdog expired with the tests still running");
    $display("=== FAIL ===");
    $finish;
  end

  // setup cycle, then access cycles until pready, sampled at the falling edge
  task automatic apb_transfer(input bit wr, input logic [7:0] addr, input logic [31:0] wdata);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!pready && cycles < MAX_WAIT);
    if (!pready) begin
      errors++;
      $display("no pready within %0d access cycles at offset %h", MAX_WAIT, addr);
    end
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #2;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_reg(input int idx, input exec_pkg::word_t value);
    apb_transfer(1'b1, exec_pkg::ADDR_REG_SEL, 32'(idx));
    apb_transfer(1'b1, exec_pkg::ADDR_DATA_LO, value[31:0]);
    apb_transfer(1'b1, exec_pkg::ADDR_DATA_HI, value[63:32]);
    regs[idx] = value;
  endtask

  task automatic check_word(input string name, input exec_pkg::word_t exp,
                            input exec_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flags(input string name, input exec_pkg::flags_t exp,
                             input exec_pkg::flags_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s flags: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input bit exp, input bit act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // reads back one register and its flags and compares with the expected files
  task automatic check_reg(input int idx, input string name);
    exec_pkg::word_t value;
    string tag;
    tag = $sformatf("%s r%0d", name, idx);
    apb_transfer(1'b1, exec_pkg::ADDR_REG_SEL, 32'(idx));
    apb_transfer(1'b0, exec_pkg::ADDR_DATA_LO, '0);
    value[31:0] = rdata;
    apb_transfer(1'b0, exec_pkg::ADDR_DATA_HI, '0);
    value[63:32] = rdata;
    check_word(tag, regs[idx], value);
    apb_transfer(1'b0, exec_pkg::ADDR_FLAGS, '0);
    check_flags(tag, flags[idx], exec_pkg::flags_t'(rdata[3:0]));
  endtask

  // applies one instruction to the expected files
  task automatic model(input exec_pkg::opcode_e op, input exec_pkg::cond_e cond,
                       input int rd, input int ra, input int rb);
    exec_pkg::word_t a;
    exec_pkg::word_t b;
    exec_pkg::word_t r;
    exec_pkg::flags_t f;
    logic c;
    logic v;
    logic ok;
    a = regs[ra];
    b = regs[rb];
    f = flags[ra];
    r = '0;
    c = 1'b0;
    v = 1'b0;
    // odd codes invert the even code below them
    case (cond[3:1])
      3'd0: ok = f.z;
      3'd1: ok = f.c;
      3'd2: ok = f.n;
      3'd3: ok = f.v;
      3'd4: ok = f.c && !f.z;
      3'd5: ok = (f.n == f.v);
      3'd6: ok = (f.n == f.v) && !f.z;
      default: ok = 1'b1;
    endcase
    ok = ok ^ cond[0];
    case (op)
      exec_pkg::OP_ADD, exec_pkg::OP_ADDI: begin
        if (op == exec_pkg::OP_ADDI) begin
          b = imm;
        end
        {c, r} = {1'b0, a} + {1'b0, b};
        v = (a[63] == b[63]) && (r[63] != a[63]);
      end
      exec_pkg::OP_SUB: begin
        r = a - b;
        c = (a >= b);
        v = (a[63] != b[63]) && (r[63] != a[63]);
      end
      exec_pkg::OP_AND: r = a & b;
      exec_pkg::OP_XOR: r = a ^ b;
      exec_pkg::OP_OR: r = a | b;
      exec_pkg::OP_SHL: r = a << b[5:0];
      exec_pkg::OP_SHR: r = a >> b[5:0];
      exec_pkg::OP_SAR: r = $signed(a) >>> b[5:0];
      exec_pkg::OP_SXT: r = {{32{a[31]}}, a[31:0]};
      exec_pkg::OP_MOVI: r = imm;
      default: ok = 1'b0;
    endcase
    if (ok) begin
      regs[rd] = r;
      flags[rd] = {c, v, r[63], r == '0};
    end
  endtask

  task automatic issue(input exec_pkg::opcode_e op, input exec_pkg::cond_e cond,
                       input int rd, input int ra, input int rb);
    model(op, cond, rd, ra, rb);
    apb_transfer(1'b1, exec_pkg::ADDR_CMD, {12'd0, 4'(rb), 4'(ra), 4'(rd), cond, op});
  endtask

  task automatic test_regs();
    check_err("reset pready", 1'b0, pready);
    check_err("reset pslverr", 1'b0, pslverr);
    check_word("reset prdata", '0, 64'(prdata));
    for (int i = 0; i < 16; i++) begin
      set_reg(i, {$random(seed), $random(seed)});
    end
    for (int i = 0; i < 16; i++) begin
      check_reg(i, "regs");
    end
  endtask

  // carry out, signed overflow and borrow corners, then one random pair
  task automatic test_alu();
    exec_pkg::word_t a [5] = '{64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff,
                               64'h8000_0000_0000_0000, 64'd0, 64'd0};
    exec_pkg::word_t b [5] = '{64'd1, 64'd1, 64'd1, 64'd1, 64'd0};
    exec_pkg::opcode_e ops [5] = '{exec_pkg::OP_ADD, exec_pkg::OP_SUB, exec_pkg::OP_AND,
                                   exec_pkg::OP_XOR, exec_pkg::OP_OR};
    a[4] = {$random(seed), $random(seed)};
    b[4] = {$random(seed), $random(seed)};
    for (int i = 0; i < 5; i++) begin
      set_reg(1, a[i]);
      set_reg(2, b[i]);
      for (int j = 0; j < 5; j++) begin
        issue(ops[j], exec_pkg::COND_AL, 3, 1, 2);
        check_reg(3, $sformatf("alu %s", ops[j].name()));
      end
    end
  endtask

  task automatic test_cond();
    set_reg(1, 64'h1234_5678_9abc_def0);
    set_reg(2, 64'h1234_5678_9abc_def0);
    issue(exec_pkg::OP_SUB, exec_pkg::COND_AL, 3, 1, 2);
    // equal operands give zero and no borrow
    apb_transfer(1'b1, exec_pkg::ADDR_REG_SEL, 32'd3);
    apb_transfer(1'b0, exec_pkg::ADDR_FLAGS, '0);
    check_flags("cond zero", 4'b1001, exec_pkg::flags_t'(rdata[3:0]));
    // negative result in r7, unlike anything ne or nv would write
    issue(exec_pkg::OP_SUB, exec_pkg::COND_AL, 7, 3, 1);
    // r3 has zero set, so only EQ writes back
    issue(exec_pkg::OP_ADD, exec_pkg::COND_EQ, 6, 3, 1);
    issue(exec_pkg::OP_XOR, exec_pkg::COND_NE, 7, 3, 1);
    issue(exec_pkg::OP_OR, exec_pkg::COND_NV, 7, 3, 2);
    check_reg(3, "cond sub");
    check_reg(6, "cond eq");
    check_reg(7, "cond ne nv");
  endtask

  task automatic test_imm();
    imm = 64'hfedc_ba98_7654_3210;
    apb_transfer(1'b1, exec_pkg::ADDR_IMM_LO, imm[31:0]);
    apb_transfer(1'b1, exec_pkg::ADDR_IMM_HI, imm[63:32]);
    issue(exec_pkg::OP_MOVI, exec_pkg::COND_AL, 8, 0, 0);
    issue(exec_pkg::OP_ADDI, exec_pkg::COND_AL, 9, 8, 0);
    set_reg(10, 64'h0000_0000_8000_1234);
    set_reg(11, 64'hffff_ffff_7fff_0001);
    issue(exec_pkg::OP_SXT, exec_pkg::COND_AL, 12, 10, 0);
    issue(exec_pkg::OP_SXT, exec_pkg::COND_AL, 13, 11, 0);
    for (int i = 8; i < 14; i++) begin
      check_reg(i, "imm");
    end
  endtask

  task automatic test_shift();
    // last amount is 5 with the upper bits set
    exec_pkg::word_t amt [4] = '{64'd0, 64'd1, 64'd63, 64'hffff_ffff_ffff_ffc5};
    exec_pkg::opcode_e ops [3] = '{exec_pkg::OP_SHL, exec_pkg::OP_SHR, exec_pkg::OP_SAR};
    set_reg(1, 64'h8123_4567_89ab_cdef);
    for (int i = 0; i < 4; i++) begin
      set_reg(2, amt[i]);
      for (int j = 0; j < 3; j++) begin
        issue(ops[j], exec_pkg::COND_AL, 3, 1, 2);
        check_reg(3, $sformatf("%s by %h", ops[j].name(), amt[i]));
      end
    end
  endtask

  task automatic test_unmapped();
    apb_transfer(1'b1, 8'h40, 32'hdead_beef);
    check_err("unmapped write", 1'b1, err);
    apb_transfer(1'b0, 8'h1c, '0);
    check_err("unmapped read", 1'b1, err);
    // CMD reads as zero without an error
    apb_transfer(1'b0, exec_pkg::ADDR_CMD, '0);
    check_err("cmd read", 1'b0, err);
    check_word("cmd read", '0, 64'(rdata));
    for (int i = 0; i < 16; i++) begin
      check_reg(i, "unmapped");
    end
    issue(exec_pkg::OP_AND, exec_pkg::COND_AL, 4, 1, 2);
    checks++;
    if (cycles != 3) begin
      errors++;
      $display("CMD write took %0d access cycles instead of 3", cycles);
    end
    check_reg(4, "cmd timing");
  endtask

  initial begin
    int start;
    string names [NUM_TESTS];
    names = '{"regs", "alu", "cond", "imm", "shift", "unmapped"};
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      start = errors;
      case (t)
        0: test_regs();
        1: test_alu();
        2: test_cond();
        3: test_imm();
        4: test_shift();
        default: test_unmapped();
      endcase
      $display("test %s done, %0d errors", names[t], errors - start);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
